/* design/io_reg_pkg.sv */
// Shared definitions for the I/O control and boot-identification registers
// Holds the address map, register widths, FSM encodings and board constants
// Other files refer to these by scoped name only
`default_nettype none

package io_reg_pkg;

  // Bus and register widths
  localparam int ADDR_W = 4;
  localparam int DATA_W = 32;
  localparam int IOC_W  = 8;
  localparam int ALD_W  = 16;
  localparam int INR_W  = 8;

  typedef logic [ADDR_W-1:0] io_addr_t;  // AXI byte address
  typedef logic [DATA_W-1:0] io_data_t;  // AXI data word
  typedef logic [IOC_W-1:0]  ioc_t;      // IOC register contents
  typedef logic [ALD_W-1:0]  ald_t;      // Boot identification word
  typedef logic [INR_W-1:0]  inr_t;      // INR input byte

  // IOC bit positions
  localparam int IOC_CLK_IE  = 0;  // Enable clock interrupt, level 13
  localparam int IOC_IN_IE   = 1;  // Enable input interrupt, level 12
  localparam int IOC_OUT_IE  = 2;  // Enable output interrupt, level 10
  localparam int IOC_CLK_REQ = 3;  // Clock interrupt request from RTC handler
  localparam int IOC_GREEN_N = 4;  // Green LED, active low
  localparam int IOC_EMCL_N  = 5;  // Master-clear enable, active low
  localparam int IOC_CONS_N  = 6;  // Console select, active low
  localparam int IOC_RTC_CLR = 7;  // Real-time clock clear

  // Register map, word aligned
  localparam io_addr_t ADDR_IOC = 4'h0;
  localparam io_addr_t ADDR_ALD = 4'h4;
  localparam io_addr_t ADDR_INR = 4'h8;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Register picked by the address decode
  typedef enum logic [1:0] {
    SEL_IOC,
    SEL_ALD,
    SEL_INR,
    SEL_NONE   // Unmapped address
  } reg_sel_t;

  // Bus slave FSM
  typedef enum logic [1:0] {
    ST_IDLE,   // Waiting for a request
    ST_WRESP,  // Write response pending
    ST_RRESP   // Read response pending
  } axil_state_t;

  // Board revision constants
  localparam logic [2:0] PRINT_NO   = 3'd3;     // Print number of revision D
  localparam logic [3:0] ALD_SWITCH = 4'd4;     // Boot from paper tape reader
  // Strap5 in bit 4 down to strap9 in bit 0, a fitted strap reads 0
  localparam logic [4:0] STRAP_BITS = 5'b10100;

endpackage

`default_nettype wire

/* design/io_bus_if.sv */
// Register-access bus between the AXI4-Lite slave and the register blocks
// The slave issues one-cycle strobes with a register select
// The read side returns data combinationally from the select
`default_nettype none

interface io_bus_if (
  input wire logic clk,   // Only for checks on the read side
  input wire logic rst_n
);

  logic                  wr_stb;  // One-cycle write pulse
  logic                  rd_stb;  // One-cycle read pulse
  io_reg_pkg::reg_sel_t  sel;     // Decoded target register
  io_reg_pkg::ioc_t      wdata;   // Low byte of the AXI write data
  io_reg_pkg::io_data_t  rdata;   // Selected register, zero extended

  // Bus slave drives strobes, select and write data
  modport ctrl (
    output wr_stb,
    output rd_stb,
    output sel,
    output wdata,
    input  rdata
  );

  // IOC register block
  modport ioc_side (
    input wr_stb,
    input sel,
    input wdata
  );

  // Read mux, wr_stb only for the strobe overlap check
  modport read_side (
    input  clk,
    input  rst_n,
    input  rd_stb,
    input  wr_stb,
    input  sel,
    output rdata
  );

endinterface

`default_nettype wire

/* design/io_axil_slave.sv */
// AXI4-Lite slave for the I/O register block
// Serves one transaction at a time, writes win over reads
// Decodes the address, pulses a register strobe on the accepting edge
// and returns a registered response one cycle later
`default_nettype none

module io_axil_slave (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  // Write address channel
  input  wire io_reg_pkg::io_addr_t awaddr,
  input  wire logic                 awvalid,
  output logic                      awready,
  // Write data channel
  input  wire io_reg_pkg::io_data_t wdata,
  input  wire logic [3:0]           wstrb,
  input  wire logic                 wvalid,
  output logic                      wready,
  // Write response channel
  output logic [1:0]                bresp,
  output logic                      bvalid,
  input  wire logic                 bready,
  // Read address channel
  input  wire io_reg_pkg::io_addr_t araddr,
  input  wire logic                 arvalid,
  output logic                      arready,
  // Read data channel
  output io_reg_pkg::io_data_t      rdata,
  output logic [1:0]                rresp,
  output logic                      rvalid,
  input  wire logic                 rready,
  // Register strobes
  io_bus_if.ctrl                    bus
);

  io_reg_pkg::axil_state_t state, state_nxt;
  io_reg_pkg::reg_sel_t    wr_sel;
  io_reg_pkg::reg_sel_t    rd_sel;
  logic                    wr_acc;   // Write handshake on this edge
  logic                    rd_acc;   // Read handshake on this edge

  // Address to register select, anything off the map is SEL_NONE
  function automatic io_reg_pkg::reg_sel_t decode_sel(input io_reg_pkg::io_addr_t addr);
    io_reg_pkg::reg_sel_t s;
    case (addr)
      io_reg_pkg::ADDR_IOC: s = io_reg_pkg::SEL_IOC;
      io_reg_pkg::ADDR_ALD: s = io_reg_pkg::SEL_ALD;
      io_reg_pkg::ADDR_INR: s = io_reg_pkg::SEL_INR;
      default:              s = io_reg_pkg::SEL_NONE;
    endcase
    return s;
  endfunction

  assign wr_sel = decode_sel(awaddr);
  assign rd_sel = decode_sel(araddr);

  // Address and data taken together, only when both are offered
  assign wr_acc = (state == io_reg_pkg::ST_IDLE) && awvalid && wvalid;
  // Read held off while any part of a write is waiting
  assign rd_acc = (state == io_reg_pkg::ST_IDLE) && arvalid && !awvalid && !wvalid;

  assign awready = wr_acc;
  assign wready  = wr_acc;
  assign arready = rd_acc;

  // Strobes fire in the handshake cycle
  assign bus.sel    = wr_acc ? wr_sel : rd_sel;
  assign bus.wr_stb = wr_acc && wstrb[0] && (wr_sel == io_reg_pkg::SEL_IOC);
  assign bus.rd_stb = rd_acc;
  assign bus.wdata  = wdata[io_reg_pkg::IOC_W-1:0];  // Only byte lane 0 is mapped

  assign bvalid = (state == io_reg_pkg::ST_WRESP);
  assign rvalid = (state == io_reg_pkg::ST_RRESP);

  always_comb begin
    state_nxt = state;
    case (state)
      io_reg_pkg::ST_IDLE: begin
        if (wr_acc) begin
          state_nxt = io_reg_pkg::ST_WRESP;
        end else if (rd_acc) begin
          state_nxt = io_reg_pkg::ST_RRESP;
        end
      end
      io_reg_pkg::ST_WRESP: begin
        if (bready) state_nxt = io_reg_pkg::ST_IDLE;  // Response taken
      end
      io_reg_pkg::ST_RRESP: begin
        if (rready) state_nxt = io_reg_pkg::ST_IDLE;
      end
      default: state_nxt = io_reg_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= io_reg_pkg::ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Response payload, held until the next accepted transaction
  always_ff @(posedge clk) begin
    if (wr_acc) begin
      // Writes only land on IOC, a cleared byte strobe is still OKAY
      bresp <= (wr_sel == io_reg_pkg::SEL_IOC) ? io_reg_pkg::RESP_OKAY
                                                : io_reg_pkg::RESP_SLVERR;
    end
    if (rd_acc) begin
      rdata <= bus.rdata;  // Sampled together with cx_n and inr
      rresp <= (rd_sel == io_reg_pkg::SEL_NONE) ? io_reg_pkg::RESP_SLVERR
                                                 : io_reg_pkg::RESP_OKAY;
    end
  end

  // Write response held with a stable code until taken
  a_bvalid_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp)
  );

  // Read response and data held until taken
  a_rvalid_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
  );

endmodule

`default_nettype wire

/* design/ioc_reg.sv */
// IOC control register with the interrupt, console and LED decode
// Loads from the register bus on a write strobe to SEL_IOC
// UART status inputs are synchronized before they gate levels 10 and 12
`default_nettype none

module ioc_reg (
  input  wire logic        clk,
  input  wire logic        rst_n,
  io_bus_if.ioc_side       bus,
  input  wire logic        tbmt_n,     // UART transmit buffer empty, async
  input  wire logic        da_n,       // UART data available, async
  output io_reg_pkg::ioc_t ioc_q,      // Current value for read back
  output logic             bint10_n,   // Output interrupt, level 10
  output logic             bint12_n,   // Input interrupt, level 12
  output logic             bint13_n,   // Clock interrupt, level 13
  output logic             console_n,
  output logic             emcl_n,
  output logic             rtc_clear,
  output logic [1:0]       ioled       // Bit 0 red, bit 1 green
);

  logic tbmt_meta, tbmt_sync;  // Two-flop synchronizer for tbmt_n
  logic da_meta, da_sync;      // Two-flop synchronizer for da_n
  logic ioc_ld;

  assign ioc_ld = bus.wr_stb && (bus.sel == io_reg_pkg::SEL_IOC);

  // Control register, cleared by reset like the old master clear
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ioc_q <= '0;
    end else if (ioc_ld) begin
      ioc_q <= bus.wdata;
    end
  end

  // Status lines idle high
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tbmt_meta <= 1'b1;
      tbmt_sync <= 1'b1;
      da_meta   <= 1'b1;
      da_sync   <= 1'b1;
    end else begin
      tbmt_meta <= tbmt_n;
      tbmt_sync <= tbmt_meta;
      da_meta   <= da_n;
      da_sync   <= da_meta;
    end
  end

  // Clock interrupt when the RTC handler requests it and it is enabled
  assign bint13_n = ~(ioc_q[io_reg_pkg::IOC_CLK_REQ] & ioc_q[io_reg_pkg::IOC_CLK_IE]);

  // Transmitter empty
  assign bint10_n = ~(ioc_q[io_reg_pkg::IOC_OUT_IE] & ~tbmt_sync);

  // Receiver ready, only while the console line is deselected
  assign bint12_n = ~(ioc_q[io_reg_pkg::IOC_CONS_N] & ioc_q[io_reg_pkg::IOC_IN_IE] &
                      ~da_sync);

  assign console_n = ioc_q[io_reg_pkg::IOC_CONS_N];
  assign emcl_n    = ioc_q[io_reg_pkg::IOC_EMCL_N];
  assign rtc_clear = ioc_q[io_reg_pkg::IOC_RTC_CLR];

  assign ioled[0] = emcl_n;                           // Red lit during master clear
  assign ioled[1] = ioc_q[io_reg_pkg::IOC_GREEN_N];   // Green after init

  // ALD and INR are read only, the slave must never strobe a write at them
  a_no_ro_write : assert property (
    @(posedge clk) disable iff (!rst_n)
    bus.wr_stb |-> !(bus.sel inside {io_reg_pkg::SEL_ALD, io_reg_pkg::SEL_INR})
  );

endmodule

`default_nettype wire

/* design/io_read_mux.sv */
// Read data path of the register block
// Builds the ALD boot-identification word and picks IOC, ALD or INR by select
// Purely combinational, the slave captures the result at its read strobe
`default_nettype none

module io_read_mux (
  io_bus_if.read_side          bus,
  input  wire io_reg_pkg::ioc_t ioc_q,  // IOC read back
  input  wire logic             cx_n,   // Live board input, lands in ALD bit 7
  input  wire io_reg_pkg::inr_t inr
);

  io_reg_pkg::ald_t ald;

  // ALD word, 0xF4B4 with cx_n high on this revision
  assign ald = {
    3'b111,                   // Unused, pulled high
    io_reg_pkg::STRAP_BITS,   // Strap5 in bit 12 down to strap9 in bit 8
    cx_n,
    io_reg_pkg::PRINT_NO,     // Board revision
    io_reg_pkg::ALD_SWITCH    // Boot switch setting
  };

  always_comb begin
    case (bus.sel)
      io_reg_pkg::SEL_IOC: begin
        bus.rdata = {{(io_reg_pkg::DATA_W - io_reg_pkg::IOC_W){1'b0}}, ioc_q};
      end
      io_reg_pkg::SEL_ALD: begin
        bus.rdata = {{(io_reg_pkg::DATA_W - io_reg_pkg::ALD_W){1'b0}}, ald};
      end
      io_reg_pkg::SEL_INR: begin
        bus.rdata = {{(io_reg_pkg::DATA_W - io_reg_pkg::INR_W){1'b0}}, inr};
      end
      default: bus.rdata = '0;  // Unmapped reads as zero
    endcase
  end

  // Slave serves one transaction at a time
  a_stb_excl : assert property (
    @(posedge bus.clk) disable iff (!bus.rst_n)
    !(bus.rd_stb && bus.wr_stb)
  );

endmodule

`default_nettype wire

/* design/io_reg_top.sv */
// Top level of the I/O control and boot-identification register block
// Plain AXI4-Lite slave ports on one side, board signals on the other
// Connects the bus slave, IOC register and read mux through io_bus_if
`default_nettype none

module io_reg_top (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  // AXI4-Lite write address
  input  wire io_reg_pkg::io_addr_t awaddr,
  input  wire logic                 awvalid,
  output logic                      awready,
  // AXI4-Lite write data
  input  wire io_reg_pkg::io_data_t wdata,
  input  wire logic [3:0]           wstrb,
  input  wire logic                 wvalid,
  output logic                      wready,
  // AXI4-Lite write response
  output logic [1:0]                bresp,
  output logic                      bvalid,
  input  wire logic                 bready,
  // AXI4-Lite read address
  input  wire io_reg_pkg::io_addr_t araddr,
  input  wire logic                 arvalid,
  output logic                      arready,
  // AXI4-Lite read data
  output io_reg_pkg::io_data_t      rdata,
  output logic [1:0]                rresp,
  output logic                      rvalid,
  input  wire logic                 rready,
  // Board inputs
  input  wire logic                 cx_n,
  input  wire logic                 tbmt_n,  // Async UART status
  input  wire logic                 da_n,    // Async UART status
  input  wire io_reg_pkg::inr_t     inr,
  // Board outputs
  output logic                      bint10_n,
  output logic                      bint12_n,
  output logic                      bint13_n,
  output logic                      console_n,
  output logic                      emcl_n,
  output logic                      rtc_clear,
  output logic [1:0]                ioled    // Bit 0 red, bit 1 green
);

  io_reg_pkg::ioc_t ioc_q;  // IOC value for read back

  io_bus_if i_bus (
    .clk   (clk),
    .rst_n (rst_n)
  );

  io_axil_slave i_slave (
    .clk     (clk),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .bus     (i_bus.ctrl)
  );

  ioc_reg i_ioc (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus       (i_bus.ioc_side),
    .tbmt_n    (tbmt_n),
    .da_n      (da_n),
    .ioc_q     (ioc_q),
    .bint10_n  (bint10_n),
    .bint12_n  (bint12_n),
    .bint13_n  (bint13_n),
    .console_n (console_n),
    .emcl_n    (emcl_n),
    .rtc_clear (rtc_clear),
    .ioled     (ioled)
  );

  io_read_mux i_rmux (
    .bus   (i_bus.read_side),
    .ioc_q (ioc_q),
    .cx_n  (cx_n),
    .inr   (inr)
  );

endmodule

`default_nettype wire

/* tests/tb_io_reg.sv */
// Directed testbench for the I/O control and boot-identification registers
// Drives io_reg_top over AXI4-Lite and checks board outputs and read data
// Each test is a task, the first mismatch stops the run
`default_nettype none

module tb_io_reg;

  localparam int TIMEOUT = 20;  // Cycles allowed for any handshake

  logic        clk = 1'b0;
  logic        rst_n;
  logic [3:0]  awaddr;
  logic        awvalid, awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid, wready;
  logic [1:0]  bresp;
  logic        bvalid, bready;
  logic [3:0]  araddr;
  logic        arvalid, arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid, rready;
  logic        cx_n, tbmt_n, da_n;
  logic [7:0]  inr;
  logic        bint10_n, bint12_n, bint13_n;
  logic        console_n, emcl_n, rtc_clear;
  logic [1:0]  ioled;
  logic [7:0]  ioc_exp;  // Expected IOC contents

  io_reg_top i_dut (
    .clk(clk), .rst_n(rst_n),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .cx_n(cx_n), .tbmt_n(tbmt_n), .da_n(da_n), .inr(inr),
    .bint10_n(bint10_n), .bint12_n(bint12_n), .bint13_n(bint13_n),
    .console_n(console_n), .emcl_n(emcl_n), .rtc_clear(rtc_clear), .ioled(ioled)
  );

  always #4 clk = ~clk;  // Period 8

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // Offer address and data, return on the falling edge after the handshake
  task automatic send_write(input logic [3:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    int n;
    n = 0;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    #1;
    while (!(awready && wready)) begin
      n++;
      if (n > TIMEOUT) abort_run("write address and data were never accepted");
      @(negedge clk);
      #1;
    end
    @(negedge clk);  // Taken on the rising edge in between
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task automatic take_bresp(output logic [1:0] r);
    int n;
    n = 0;
    while (!bvalid) begin
      n++;
      if (n > TIMEOUT) abort_run("write response never arrived");
      @(negedge clk);
    end
    r = bresp;
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic send_read(input logic [3:0] addr);
    int n;
    n = 0;
    araddr  = addr;
    arvalid = 1'b1;
    #1;
    while (!arready) begin
      n++;
      if (n > TIMEOUT) abort_run("read address was never accepted");
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    arvalid = 1'b0;
  endtask

  task automatic take_rdata(output logic [31:0] d, output logic [1:0] r);
    int n;
    n = 0;
    while (!rvalid) begin
      n++;
      if (n > TIMEOUT) abort_run("read data never arrived");
      @(negedge clk);
    end
    d = rdata;
    r = rresp;
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic [1:0] exp_resp);
    logic [1:0] r;
    send_write(addr, data, strb);
    take_bresp(r);
    check("bresp", 32'(r), 32'(exp_resp));
  endtask

  task automatic axil_read(input logic [3:0] addr, input logic [31:0] exp_data,
                           input logic [1:0] exp_resp);
    logic [31:0] d;
    logic [1:0]  r;
    send_read(addr);
    take_rdata(d, r);
    check("rdata", d, exp_data);
    check("rresp", 32'(r), 32'(exp_resp));
  endtask

  // Board outputs that follow IOC bits directly
  task automatic check_outputs();
    check("console_n", 32'(console_n), 32'(ioc_exp[6]));
    check("emcl_n", 32'(emcl_n), 32'(ioc_exp[5]));
    check("rtc_clear", 32'(rtc_clear), 32'(ioc_exp[7]));
    check("ioled", 32'(ioled), 32'({ioc_exp[4], ioc_exp[5]}));  // Red copies emcl_n
    check("bint13_n", 32'(bint13_n), 32'(!(ioc_exp[3] && ioc_exp[0])));
  endtask

  task automatic reset_test();
    ioc_exp = 8'h00;
    check("bint10_n", 32'(bint10_n), 32'h1);
    check("bint12_n", 32'(bint12_n), 32'h1);
    check_outputs();
    axil_read(io_reg_pkg::ADDR_IOC, 32'h0, io_reg_pkg::RESP_OKAY);
  endtask

  task automatic ioc_write_test();
    logic [7:0] v;
    repeat (10) begin
      v = 8'($urandom);
      axil_write(io_reg_pkg::ADDR_IOC, {24'h0, v}, 4'hf, io_reg_pkg::RESP_OKAY);
      ioc_exp = v;
      check_outputs();
      axil_read(io_reg_pkg::ADDR_IOC, {24'h0, v}, io_reg_pkg::RESP_OKAY);
      // Lane 0 strobe clear, register must keep its value
      axil_write(io_reg_pkg::ADDR_IOC, {24'h0, ~v}, 4'he, io_reg_pkg::RESP_OKAY);
      axil_read(io_reg_pkg::ADDR_IOC, {24'h0, v}, io_reg_pkg::RESP_OKAY);
    end
  endtask

  task automatic irq_test();
    int n;
    axil_write(io_reg_pkg::ADDR_IOC, 32'h46, 4'h1, io_reg_pkg::RESP_OKAY);  // Bits 6, 2, 1
    check("bint10_n", 32'(bint10_n), 32'h1);
    check("bint12_n", 32'(bint12_n), 32'h1);
    tbmt_n = 1'b0;
    da_n   = 1'b0;
    n = 0;
    while (bint10_n || bint12_n) begin
      n++;
      if (n > 3) abort_run("bint10_n and bint12_n did not fall within 3 cycles");
      @(negedge clk);
    end
    axil_write(io_reg_pkg::ADDR_IOC, 32'h06, 4'h1, io_reg_pkg::RESP_OKAY);  // Bit 6 off
    check("bint12_n", 32'(bint12_n), 32'h1);
    check("bint10_n", 32'(bint10_n), 32'h0);
    axil_write(io_reg_pkg::ADDR_IOC, 32'h46, 4'h1, io_reg_pkg::RESP_OKAY);
    check("bint12_n", 32'(bint12_n), 32'h0);
    axil_write(io_reg_pkg::ADDR_IOC, 32'h44, 4'h1, io_reg_pkg::RESP_OKAY);  // Bit 1 off
    check("bint12_n", 32'(bint12_n), 32'h1);
    ioc_exp = 8'h44;
    tbmt_n = 1'b1;
    da_n   = 1'b1;
    n = 0;
    while (!bint10_n) begin
      n++;
      if (n > 3) abort_run("bint10_n did not rise after tbmt_n went high");
      @(negedge clk);
    end
  endtask

  task automatic ald_inr_test();
    cx_n = 1'b1;
    axil_read(io_reg_pkg::ADDR_ALD, 32'h0000_f4b4, io_reg_pkg::RESP_OKAY);
    cx_n = 1'b0;
    axil_read(io_reg_pkg::ADDR_ALD, 32'h0000_f434, io_reg_pkg::RESP_OKAY);
    cx_n = 1'b1;
    inr  = 8'($urandom);
    axil_read(io_reg_pkg::ADDR_INR, {24'h0, inr}, io_reg_pkg::RESP_OKAY);
  endtask

  task automatic error_test();
    axil_write(io_reg_pkg::ADDR_ALD, 32'hff, 4'hf, io_reg_pkg::RESP_SLVERR);
    axil_write(io_reg_pkg::ADDR_INR, 32'hff, 4'hf, io_reg_pkg::RESP_SLVERR);
    axil_write(4'hc, 32'hff, 4'hf, io_reg_pkg::RESP_SLVERR);
    axil_read(io_reg_pkg::ADDR_IOC, {24'h0, ioc_exp}, io_reg_pkg::RESP_OKAY);
    axil_read(4'hc, 32'h0, io_reg_pkg::RESP_SLVERR);
  endtask

  task automatic backpressure_test();
    logic [1:0]  r;
    logic [31:0] d;
    send_write(io_reg_pkg::ADDR_IOC, 32'h5a, 4'h1);
    ioc_exp = 8'h5a;
    araddr  = io_reg_pkg::ADDR_IOC;
    arvalid = 1'b1;  // Read waits behind the pending write response
    repeat (5) begin
      #1;
      check("bvalid", 32'(bvalid), 32'h1);
      check("arready", 32'(arready), 32'h0);
      @(negedge clk);
    end
    take_bresp(r);
    check("bresp", 32'(r), 32'(io_reg_pkg::RESP_OKAY));
    send_read(io_reg_pkg::ADDR_IOC);
    awaddr  = io_reg_pkg::ADDR_IOC;  // Write offered during read stall
    wdata   = 32'ha5;
    wstrb   = 4'h0;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    repeat (5) begin
      #1;
      check("rvalid", 32'(rvalid), 32'h1);
      check("awready", 32'(awready), 32'h0);
      check("wready", 32'(wready), 32'h0);
      @(negedge clk);
    end
    take_rdata(d, r);
    check("rdata", d, 32'h5a);
    check("rresp", 32'(r), 32'(io_reg_pkg::RESP_OKAY));
    axil_write(io_reg_pkg::ADDR_IOC, 32'ha5, 4'h0, io_reg_pkg::RESP_OKAY);
    axil_read(io_reg_pkg::ADDR_IOC, 32'h5a, io_reg_pkg::RESP_OKAY);
  endtask

  initial begin
    void'($urandom(32'h9c21));
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    cx_n    = 1'b1;
    tbmt_n  = 1'b1;
    da_n    = 1'b1;
    inr     = '0;
    ioc_exp = '0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    reset_test();
    ioc_write_test();
    irq_test();
    ald_inr_test();
    error_test();
    backpressure_test();
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
design/io_reg_pkg.sv
design/io_bus_if.sv
design/io_axil_slave.sv
design/ioc_reg.sv
design/io_read_mux.sv
design/io_reg_top.sv
tests/tb_io_reg.sv

/* run.sh */
#!/bin/sh
# Build and run the register block testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module tb_io_reg -o sim_io_reg \
  && ./obj_dir/sim_io_reg > sim.log 2>&1
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
